// File: hdl/basics_pkg.sv
`default_nettype none

package basics_pkg;

	// Command bytes from the host
	localparam logic [7:0] CMD_VERSION    = 8'h76;
	localparam logic [7:0] CMD_QUERY_I2C  = 8'h49;
	localparam logic [7:0] CMD_SET_I2C    = 8'h69;
	localparam logic [7:0] CMD_QUERY_GPIO = 8'h47;
	localparam logic [7:0] CMD_SET_GPIO   = 8'h67;

	// Sub-codes that pick a setting
	localparam logic [7:0] SUB_I2C_SPEED  = 8'h63;
	localparam logic [7:0] SUB_I2C_ADDR   = 8'h61;
	localparam logic [7:0] SUB_GPIO_LEVEL = 8'h6c;
	localparam logic [7:0] SUB_GPIO_DIR   = 8'h64;
	localparam logic [7:0] SUB_GPIO_INT   = 8'h69;

	// Reply code bytes
	localparam logic [7:0] ACK_CODE = 8'h00;
	localparam logic [7:0] NAK_CODE = 8'h01;

	localparam int GPIO_W  = 24;
	localparam int PARAM_W = 24;

	localparam logic [7:0]        I2C_SPEED_RST = 8'd99;
	localparam logic [15:0]       I2C_ADDR_RST  = 16'hFFFF;
	localparam logic [GPIO_W-1:0] GPIO_RST      = '0;

	typedef enum logic [2:0] {
		SEL_NONE,
		SEL_I2C_SPEED,
		SEL_I2C_ADDR,
		SEL_GPIO_LEVEL,
		SEL_GPIO_DIR,
		SEL_GPIO_INT,
		SEL_VERSION
	} param_sel_t;

	typedef struct packed {
		logic [7:0] data;
		logic       data_valid;
		logic       frame_valid;
	} rx_byte_t;

	typedef struct packed {
		logic [7:0] data;
		logic       last;
	} reply_byte_t;

	typedef struct packed {
		logic [7:0] code;
		logic [7:0] eid;
		logic [7:0] length;
	} ack_req_t;

	// Number of value bytes carried by each setting
	function automatic logic [1:0] sel_bytes(input param_sel_t sel);
		case (sel)
			SEL_I2C_SPEED:                              return 2'd1;
			SEL_I2C_ADDR, SEL_VERSION:                  return 2'd2;
			SEL_GPIO_LEVEL, SEL_GPIO_DIR, SEL_GPIO_INT: return 2'd3;
			default:                                    return 2'd0;
		endcase
	endfunction

endpackage

`default_nettype wire

// File: hdl/ack_generator.sv
`timescale 1ns/10ps
`default_nettype none

module ack_generator (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    ack_start,
	input  basics_pkg::ack_req_t    ack_req,
	output basics_pkg::reply_byte_t ack_byte,
	output logic                    ack_valid,
	output logic                    ack_busy
);
	import basics_pkg::*;

	ack_req_t   req_q;
	logic [1:0] step;

	// Step 1 code, 2 EID, 3 length
	always_ff @(posedge clk) begin
		if (rst)
			step <= 2'd0;
		else if (ack_start)
			step <= 2'd1;
		else if (step == 2'd3)
			step <= 2'd0;
		else if (step != 2'd0)
			step <= step + 2'd1;
	end

	always_ff @(posedge clk) begin
		if (ack_start)
			req_q <= ack_req;
	end

	always_comb begin
		case (step)
			2'd1:    ack_byte.data = req_q.code;
			2'd2:    ack_byte.data = req_q.eid;
			default: ack_byte.data = req_q.length;
		endcase
		// An empty reply ends on its length byte
		ack_byte.last = (step == 2'd3) && (req_q.length == 8'd0);
	end

	assign ack_valid = (step != 2'd0);
	assign ack_busy = (step != 2'd0);

	a_no_restart: assert property (@(posedge clk) disable iff (rst) ack_start |-> !ack_busy);

endmodule

`default_nettype wire

// File: hdl/settings_regs.sv
`timescale 1ns/10ps
`default_nettype none

module settings_regs #(
	parameter logic [7:0] VERSION_MAJOR = 8'h00,
	parameter logic [7:0] VERSION_MINOR = 8'h04
) (
	input  logic                          clk,
	input  logic                          rst,
	input  basics_pkg::rx_byte_t          rx,
	input  logic [basics_pkg::GPIO_W-1:0] gpio_read,
	input  basics_pkg::param_sel_t        sel,
	input  logic                          wr_en,
	input  logic                          rd_start,
	input  logic                          commit,
	output basics_pkg::reply_byte_t       rd_byte,
	output logic                          rd_valid,
	output logic [7:0]                    i2c_speed,
	output logic [15:0]                   i2c_addr,
	output logic [basics_pkg::GPIO_W-1:0] gpio_level,
	output logic [basics_pkg::GPIO_W-1:0] gpio_direction,
	output logic [basics_pkg::GPIO_W-1:0] gpio_int_enable
);
	import basics_pkg::*;

	logic [GPIO_W-1:0]  level_stg;
	logic [GPIO_W-1:0]  dir_stg;
	logic [GPIO_W-1:0]  int_stg;
	param_sel_t         gpio_target;
	logic [PARAM_W-1:0] rd_sr;
	logic [1:0]         rd_cnt;

	// I2C values change as bytes arrive, GPIO only on commit
	always_ff @(posedge clk) begin
		if (rst) begin
			i2c_speed <= I2C_SPEED_RST;
			i2c_addr <= I2C_ADDR_RST;
			gpio_level <= GPIO_RST;
			gpio_direction <= GPIO_RST;
			gpio_int_enable <= GPIO_RST;
			gpio_target <= SEL_NONE;
		end else begin
			if (wr_en) begin
				case (sel)
					SEL_I2C_SPEED: i2c_speed <= rx.data;
					SEL_I2C_ADDR:  i2c_addr <= {i2c_addr[7:0], rx.data};
					SEL_GPIO_LEVEL, SEL_GPIO_DIR, SEL_GPIO_INT: gpio_target <= sel;
					default: ;
				endcase
			end
			if (commit) begin
				case (gpio_target)
					SEL_GPIO_LEVEL: gpio_level <= level_stg;
					SEL_GPIO_DIR:   gpio_direction <= dir_stg;
					SEL_GPIO_INT:   gpio_int_enable <= int_stg;
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en) begin
			case (sel)
				SEL_GPIO_LEVEL: level_stg <= {level_stg[GPIO_W-9:0], rx.data};
				SEL_GPIO_DIR:   dir_stg <= {dir_stg[GPIO_W-9:0], rx.data};
				SEL_GPIO_INT:   int_stg <= {int_stg[GPIO_W-9:0], rx.data};
				default: ;
			endcase
		end
	end

	// Readout counts bytes left to send
	always_ff @(posedge clk) begin
		if (rst)
			rd_cnt <= 2'd0;
		else if (rd_start)
			rd_cnt <= sel_bytes(sel);
		else if (rd_cnt != 2'd0)
			rd_cnt <= rd_cnt - 2'd1;
	end

	// Value is left-aligned so the top byte goes out first
	always_ff @(posedge clk) begin
		if (rd_start) begin
			case (sel)
				SEL_I2C_SPEED:  rd_sr <= {i2c_speed, 16'h0000};
				SEL_I2C_ADDR:   rd_sr <= {i2c_addr, 8'h00};
				SEL_GPIO_LEVEL: rd_sr <= gpio_read;
				SEL_GPIO_DIR:   rd_sr <= gpio_direction;
				SEL_GPIO_INT:   rd_sr <= gpio_int_enable;
				SEL_VERSION:    rd_sr <= {VERSION_MAJOR, VERSION_MINOR, 8'h00};
				default:        rd_sr <= '0;
			endcase
		end else begin
			rd_sr <= {rd_sr[PARAM_W-9:0], 8'h00};
		end
	end

	assign rd_valid = (rd_cnt != 2'd0);
	assign rd_byte = '{data: rd_sr[PARAM_W-1 -: 8], last: (rd_cnt == 2'd1)};

endmodule

`default_nettype wire

// File: hdl/reply_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module reply_fifo #(
	parameter int FIFO_DEPTH_LOG2 = 4
) (
	input  logic                    clk,
	input  logic                    rst,
	input  basics_pkg::reply_byte_t ack_byte,
	input  logic                    ack_valid,
	input  basics_pkg::reply_byte_t rd_byte,
	input  logic                    rd_valid,
	input  logic                    reply_ready,
	output logic [7:0]              reply_data,
	output logic                    reply_last,
	output logic                    reply_valid,
	output logic                    fifo_room,
	output logic                    fifo_empty
);
	import basics_pkg::*;

	localparam int DEPTH = 1 << FIFO_DEPTH_LOG2;
	// Largest reply is three header bytes plus three data bytes
	localparam int REPLY_MAX = 6;

	reply_byte_t              mem [DEPTH];
	logic [FIFO_DEPTH_LOG2:0] wr_ptr;
	logic [FIFO_DEPTH_LOG2:0] rd_ptr;
	logic [FIFO_DEPTH_LOG2:0] count;
	reply_byte_t              wr_byte;
	reply_byte_t              head;
	logic                     push;
	logic                     pop;
	logic                     full;

	assign push = ack_valid | rd_valid;
	assign wr_byte = ack_valid ? ack_byte : rd_byte;
	assign count = wr_ptr - rd_ptr;
	assign fifo_empty = (count == '0);
	assign full = count[FIFO_DEPTH_LOG2];
	assign fifo_room = (int'(count) <= DEPTH - REPLY_MAX);

	assign head = mem[rd_ptr[FIFO_DEPTH_LOG2-1:0]];
	assign reply_valid = !fifo_empty;
	assign reply_data = head.data;
	assign reply_last = head.last;
	assign pop = reply_valid && reply_ready;

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr[FIFO_DEPTH_LOG2-1:0]] <= wr_byte;
	end

	a_single_src: assert property (@(posedge clk) disable iff (rst) !(ack_valid && rd_valid));
	a_no_overflow: assert property (@(posedge clk) disable iff (rst) push |-> !full);

endmodule

`default_nettype wire

// File: hdl/cmd_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module cmd_sequencer #(
	parameter logic [7:0] VERSION_MAJOR = 8'h00,
	parameter logic [7:0] VERSION_MINOR = 8'h04
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   generate_nak,
	input  basics_pkg::rx_byte_t   rx,
	input  logic                   ack_busy,
	input  logic                   fifo_room,
	input  logic                   fifo_empty,
	output logic                   ack_start,
	output basics_pkg::ack_req_t   ack_req,
	output basics_pkg::param_sel_t sel,
	output logic                   wr_en,
	output logic                   rd_start,
	output logic                   commit
);
	import basics_pkg::*;

	typedef enum logic [3:0] {
		S_IDLE,
		S_EID,
		S_LEN,
		S_VER,
		S_QUERY,
		S_SET_SUB,
		S_SET_DATA,
		S_REPLY,
		S_ACK_WAIT,
		S_COMMIT_WAIT
	} state_t;

	state_t     state;
	logic       fv_q;
	logic       cmd_pending;
	logic       nak_q;
	logic       nak_cmd;
	logic [7:0] cmd_q;
	logic [7:0] ver_hi;
	logic [1:0] cnt;
	logic       need_rd;
	logic       need_commit;
	logic       frame_start;
	logic       first_byte;
	logic       nak_now;
	logic       cmd_known;
	logic       is_query;
	logic       ver_match;
	logic       commit_ok;
	param_sel_t sub_sel;

	// Sub-code lookup depends on which command family is active
	function automatic param_sel_t sub_to_sel(input logic [7:0] cmd, input logic [7:0] sub);
		param_sel_t s;
		s = SEL_NONE;
		if (cmd == CMD_QUERY_I2C || cmd == CMD_SET_I2C) begin
			if (sub == SUB_I2C_SPEED)
				s = SEL_I2C_SPEED;
			else if (sub == SUB_I2C_ADDR)
				s = SEL_I2C_ADDR;
		end else begin
			if (sub == SUB_GPIO_LEVEL)
				s = SEL_GPIO_LEVEL;
			else if (sub == SUB_GPIO_DIR)
				s = SEL_GPIO_DIR;
			else if (sub == SUB_GPIO_INT)
				s = SEL_GPIO_INT;
		end
		return s;
	endfunction

	assign frame_start = rx.frame_valid & ~fv_q;
	// Command is the first valid byte after a frame start
	assign first_byte = rx.data_valid & (frame_start | cmd_pending);
	assign nak_now = frame_start ? generate_nak : nak_q;
	assign cmd_known = rx.data inside {CMD_VERSION, CMD_QUERY_I2C, CMD_SET_I2C,
		CMD_QUERY_GPIO, CMD_SET_GPIO};
	assign is_query = (cmd_q == CMD_QUERY_I2C) || (cmd_q == CMD_QUERY_GPIO);
	assign ver_match = ({ver_hi, rx.data} == {VERSION_MAJOR, VERSION_MINOR});
	assign sub_sel = sub_to_sel(cmd_q, rx.data);
	// GPIO commit waits for the ACK to drain and the frame to close
	assign commit_ok = !ack_busy && fifo_empty && !rx.frame_valid;

	assign ack_start = (state == S_REPLY) && fifo_room;
	assign rd_start = (state == S_ACK_WAIT) && !ack_busy;
	assign commit = (state == S_COMMIT_WAIT) && commit_ok;
	assign wr_en = (state == S_SET_DATA) && rx.data_valid;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= S_IDLE;
			fv_q <= 1'b0;
			cmd_pending <= 1'b0;
			nak_q <= 1'b0;
			nak_cmd <= 1'b0;
			cmd_q <= 8'h00;
			ver_hi <= 8'h00;
			cnt <= 2'd0;
			need_rd <= 1'b0;
			need_commit <= 1'b0;
			sel <= SEL_NONE;
			ack_req <= '0;
		end else begin
			fv_q <= rx.frame_valid;
			if (frame_start)
				nak_q <= generate_nak;
			if (frame_start && !rx.data_valid)
				cmd_pending <= 1'b1;
			else if (rx.data_valid)
				cmd_pending <= 1'b0;

			case (state)
				S_IDLE: begin
					// Unknown commands are dropped unless a NAK was requested
					if (first_byte && (cmd_known || nak_now)) begin
						cmd_q <= rx.data;
						nak_cmd <= nak_now;
						state <= S_EID;
					end
				end
				S_EID: begin
					if (rx.data_valid) begin
						ack_req.eid <= rx.data;
						state <= S_LEN;
					end
				end
				S_LEN: begin
					if (rx.data_valid) begin
						cnt <= 2'd2;
						need_rd <= 1'b0;
						need_commit <= 1'b0;
						if (nak_cmd) begin
							ack_req.code <= NAK_CODE;
							ack_req.length <= 8'd0;
							state <= S_REPLY;
						end else if (cmd_q == CMD_VERSION) begin
							state <= S_VER;
						end else if (is_query) begin
							state <= S_QUERY;
						end else begin
							state <= S_SET_SUB;
						end
					end
				end
				S_VER: begin
					if (rx.data_valid) begin
						if (cnt == 2'd2) begin
							ver_hi <= rx.data;
							cnt <= 2'd1;
						end else if (ver_match) begin
							ack_req.code <= ACK_CODE;
							ack_req.length <= 8'd0;
							state <= S_REPLY;
						end else begin
							// Mismatch returns our own version
							ack_req.code <= NAK_CODE;
							ack_req.length <= {6'd0, sel_bytes(SEL_VERSION)};
							sel <= SEL_VERSION;
							need_rd <= 1'b1;
							state <= S_REPLY;
						end
					end
				end
				S_QUERY: begin
					if (rx.data_valid) begin
						sel <= sub_sel;
						ack_req.length <= {6'd0, sel_bytes(sub_sel)};
						if (sub_sel == SEL_NONE) begin
							ack_req.code <= NAK_CODE;
						end else begin
							ack_req.code <= ACK_CODE;
							need_rd <= 1'b1;
						end
						state <= S_REPLY;
					end
				end
				S_SET_SUB: begin
					if (rx.data_valid) begin
						sel <= sub_sel;
						cnt <= sel_bytes(sub_sel);
						if (sub_sel == SEL_NONE) begin
							ack_req.code <= NAK_CODE;
							ack_req.length <= 8'd0;
							state <= S_REPLY;
						end else begin
							state <= S_SET_DATA;
						end
					end
				end
				S_SET_DATA: begin
					if (rx.data_valid) begin
						cnt <= cnt - 2'd1;
						if (cnt == 2'd1) begin
							ack_req.code <= ACK_CODE;
							ack_req.length <= 8'd0;
							need_commit <= sel inside {SEL_GPIO_LEVEL, SEL_GPIO_DIR, SEL_GPIO_INT};
							state <= S_REPLY;
						end
					end
				end
				S_REPLY: begin
					// Hold until the FIFO can take a whole reply
					if (fifo_room) begin
						if (need_rd)
							state <= S_ACK_WAIT;
						else if (need_commit)
							state <= S_COMMIT_WAIT;
						else
							state <= S_IDLE;
					end
				end
				S_ACK_WAIT: begin
					if (!ack_busy)
						state <= S_IDLE;
				end
				S_COMMIT_WAIT: begin
					if (commit_ok)
						state <= S_IDLE;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// Readout only starts for a decoded setting
	a_rd_sel_known: assert property (@(posedge clk) disable iff (rst) rd_start |-> sel != SEL_NONE);

endmodule

`default_nettype wire

// File: hdl/basics_top.sv
`timescale 1ns/10ps
`default_nettype none

module basics_top #(
	parameter logic [7:0] VERSION_MAJOR   = 8'h00,
	parameter logic [7:0] VERSION_MINOR   = 8'h04,
	parameter int         FIFO_DEPTH_LOG2 = 4
) (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          generate_nak,
	input  basics_pkg::rx_byte_t          rx,
	input  logic [basics_pkg::GPIO_W-1:0] gpio_read,
	input  logic                          reply_ready,
	output logic [7:0]                    reply_data,
	output logic                          reply_last,
	output logic                          reply_valid,
	output logic [7:0]                    i2c_speed,
	output logic [15:0]                   i2c_addr,
	output logic [basics_pkg::GPIO_W-1:0] gpio_level,
	output logic [basics_pkg::GPIO_W-1:0] gpio_direction,
	output logic [basics_pkg::GPIO_W-1:0] gpio_int_enable
);
	import basics_pkg::*;

	// Sequencer control
	logic       ack_start;
	ack_req_t   ack_req;
	param_sel_t sel;
	logic       wr_en;
	logic       rd_start;
	logic       commit;

	// Byte streams toward the FIFO
	reply_byte_t ack_byte;
	logic        ack_valid;
	logic        ack_busy;
	reply_byte_t rd_byte;
	logic        rd_valid;

	logic fifo_room;
	logic fifo_empty;

	cmd_sequencer #(
		.VERSION_MAJOR(VERSION_MAJOR),
		.VERSION_MINOR(VERSION_MINOR)
	) seq_i (
		.clk(clk),
		.rst(rst),
		.generate_nak(generate_nak),
		.rx(rx),
		.ack_busy(ack_busy),
		.fifo_room(fifo_room),
		.fifo_empty(fifo_empty),
		.ack_start(ack_start),
		.ack_req(ack_req),
		.sel(sel),
		.wr_en(wr_en),
		.rd_start(rd_start),
		.commit(commit)
	);

	ack_generator ack_i (
		.clk(clk),
		.rst(rst),
		.ack_start(ack_start),
		.ack_req(ack_req),
		.ack_byte(ack_byte),
		.ack_valid(ack_valid),
		.ack_busy(ack_busy)
	);

	settings_regs #(
		.VERSION_MAJOR(VERSION_MAJOR),
		.VERSION_MINOR(VERSION_MINOR)
	) regs_i (
		.clk(clk),
		.rst(rst),
		.rx(rx),
		.gpio_read(gpio_read),
		.sel(sel),
		.wr_en(wr_en),
		.rd_start(rd_start),
		.commit(commit),
		.rd_byte(rd_byte),
		.rd_valid(rd_valid),
		.i2c_speed(i2c_speed),
		.i2c_addr(i2c_addr),
		.gpio_level(gpio_level),
		.gpio_direction(gpio_direction),
		.gpio_int_enable(gpio_int_enable)
	);

	reply_fifo #(
		.FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)
	) fifo_i (
		.clk(clk),
		.rst(rst),
		.ack_byte(ack_byte),
		.ack_valid(ack_valid),
		.rd_byte(rd_byte),
		.rd_valid(rd_valid),
		.reply_ready(reply_ready),
		.reply_data(reply_data),
		.reply_last(reply_last),
		.reply_valid(reply_valid),
		.fifo_room(fifo_room),
		.fifo_empty(fifo_empty)
	);

endmodule

`default_nettype wire

// File: include/basics_model.svh
`ifndef BASICS_MODEL_SVH
`define BASICS_MODEL_SVH

typedef logic [7:0] byte_q_t[$];

localparam logic [7:0] MODEL_VER_MAJOR = 8'h00;
localparam logic [7:0] MODEL_VER_MINOR = 8'h04;

// Expected settings as seen on the DUT outputs
logic [7:0]                    model_i2c_speed;
logic [15:0]                   model_i2c_addr;
logic [basics_pkg::GPIO_W-1:0] model_gpio_level;
logic [basics_pkg::GPIO_W-1:0] model_gpio_direction;
logic [basics_pkg::GPIO_W-1:0] model_gpio_int_enable;

function automatic void reset_model();
	model_i2c_speed = basics_pkg::I2C_SPEED_RST;
	model_i2c_addr = basics_pkg::I2C_ADDR_RST;
	model_gpio_level = basics_pkg::GPIO_RST;
	model_gpio_direction = basics_pkg::GPIO_RST;
	model_gpio_int_enable = basics_pkg::GPIO_RST;
endfunction

// Frame is command, EID, length, then payload
function automatic byte_q_t expected_reply(input byte_q_t frame, input logic nak,
		input logic [basics_pkg::GPIO_W-1:0] gpio_in);
	logic [7:0]                    eid;
	logic [7:0]                    sub;
	logic [basics_pkg::GPIO_W-1:0] val;
	byte_q_t                       ack0;
	byte_q_t                       nak0;
	eid = frame[1];
	sub = frame[3];
	val = {frame[4], frame[5], frame[6]};
	ack0 = {basics_pkg::ACK_CODE, eid, 8'h00};
	nak0 = {basics_pkg::NAK_CODE, eid, 8'h00};
	if (nak)
		return nak0;
	case (frame[0])
		basics_pkg::CMD_VERSION: begin
			if (frame[3] == MODEL_VER_MAJOR && frame[4] == MODEL_VER_MINOR)
				return ack0;
			return {basics_pkg::NAK_CODE, eid, 8'h02, MODEL_VER_MAJOR, MODEL_VER_MINOR};
		end
		basics_pkg::CMD_QUERY_I2C: begin
			if (sub == basics_pkg::SUB_I2C_SPEED)
				return {basics_pkg::ACK_CODE, eid, 8'h01, model_i2c_speed};
			if (sub == basics_pkg::SUB_I2C_ADDR)
				return {basics_pkg::ACK_CODE, eid, 8'h02, model_i2c_addr[15:8], model_i2c_addr[7:0]};
			return nak0;
		end
		basics_pkg::CMD_SET_I2C: begin
			if (sub == basics_pkg::SUB_I2C_SPEED)
				model_i2c_speed = frame[4];
			else if (sub == basics_pkg::SUB_I2C_ADDR)
				model_i2c_addr = {frame[4], frame[5]};
			else
				return nak0;
			return ack0;
		end
		basics_pkg::CMD_QUERY_GPIO: begin
			if (sub == basics_pkg::SUB_GPIO_LEVEL)
				val = gpio_in;
			else if (sub == basics_pkg::SUB_GPIO_DIR)
				val = model_gpio_direction;
			else if (sub == basics_pkg::SUB_GPIO_INT)
				val = model_gpio_int_enable;
			else
				return nak0;
			return {basics_pkg::ACK_CODE, eid, 8'h03, val[23:16], val[15:8], val[7:0]};
		end
		basics_pkg::CMD_SET_GPIO: begin
			if (sub == basics_pkg::SUB_GPIO_LEVEL)
				model_gpio_level = val;
			else if (sub == basics_pkg::SUB_GPIO_DIR)
				model_gpio_direction = val;
			else if (sub == basics_pkg::SUB_GPIO_INT)
				model_gpio_int_enable = val;
			else
				return nak0;
			return ack0;
		end
		default: return {};
	endcase
endfunction

`endif

// File: test/basics_tb.sv
`timescale 1ns/10ps
`default_nettype none

module basics_tb;
	import basics_pkg::*;

	`include "basics_model.svh"

	logic              clk;
	logic              rst;
	logic              generate_nak;
	rx_byte_t          rx_in;
	logic [GPIO_W-1:0] gpio_in;
	logic              reply_ready;
	logic [7:0]        reply_data;
	logic              reply_last;
	logic              reply_valid;
	logic [7:0]        i2c_speed;
	logic [15:0]       i2c_addr;
	logic [GPIO_W-1:0] gpio_level;
	logic [GPIO_W-1:0] gpio_direction;
	logic [GPIO_W-1:0] gpio_int_enable;

	// Expected reply bytes as {data, last}
	logic [8:0] exp_q[$];
	logic       ready_random;
	string      cur_test;
	logic [7:0] eid_next;

	basics_top #(
		.VERSION_MAJOR(MODEL_VER_MAJOR),
		.VERSION_MINOR(MODEL_VER_MINOR),
		.FIFO_DEPTH_LOG2(4)
	) dut_i (
		.clk(clk),
		.rst(rst),
		.generate_nak(generate_nak),
		.rx(rx_in),
		.gpio_read(gpio_in),
		.reply_ready(reply_ready),
		.reply_data(reply_data),
		.reply_last(reply_last),
		.reply_valid(reply_valid),
		.i2c_speed(i2c_speed),
		.i2c_addr(i2c_addr),
		.gpio_level(gpio_level),
		.gpio_direction(gpio_direction),
		.gpio_int_enable(gpio_int_enable)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic abort_run();
		$display("TEST RESULT: FAIL");
		$fatal(1, "Stopping at first error");
	endtask

	task automatic compare_value(input string test, input string what,
			input logic [31:0] expected, input logic [31:0] actual);
		if (expected !== actual) begin
			$display("[FAIL] %s: %s expected 0x%0h, actual 0x%0h", test, what, expected, actual);
			abort_run();
		end
	endtask

	// Collector pops one expected byte per transfer
	always @(posedge clk) begin : collect
		logic [8:0] exp_byte;
		if (!rst && reply_valid && reply_ready) begin
			if (exp_q.size() == 0) begin
				$display("Test %s: reply byte 0x%0h arrived when no reply was expected",
					cur_test, reply_data);
				abort_run();
			end else begin
				exp_byte = exp_q.pop_front();
				compare_value(cur_test, "reply {data,last}", 32'(exp_byte),
					32'({reply_data, reply_last}));
			end
		end
	end

	// Back-pressure holds ready low about a quarter of the time
	always @(posedge clk) begin
		if (ready_random)
			reply_ready <= ($urandom_range(3, 0) != 0);
		else
			reply_ready <= 1'b1;
	end

	function automatic logic [7:0] take_eid();
		eid_next = eid_next + 8'd1;
		return eid_next;
	endfunction

	function automatic byte_q_t query_frame(input logic [7:0] cmd, input logic [7:0] sub);
		byte_q_t f;
		f = {cmd, take_eid(), 8'h01, sub};
		return f;
	endfunction

	// Value bytes go most significant first
	function automatic byte_q_t set_frame(input logic [7:0] cmd, input logic [7:0] sub,
			input logic [23:0] val, input int n);
		byte_q_t f;
		f = {cmd, take_eid(), 8'(n + 1), sub};
		for (int j = n - 1; j >= 0; j--)
			f.push_back(val[j*8 +: 8]);
		return f;
	endfunction

	function automatic byte_q_t version_frame(input logic [7:0] major, input logic [7:0] minor);
		byte_q_t f;
		f = {CMD_VERSION, take_eid(), 8'h02, major, minor};
		return f;
	endfunction

	function automatic logic settings_match();
		return (i2c_speed === model_i2c_speed) && (i2c_addr === model_i2c_addr) &&
			(gpio_level === model_gpio_level) &&
			(gpio_direction === model_gpio_direction) &&
			(gpio_int_enable === model_gpio_int_enable);
	endfunction

	task automatic set_gpio_input(input logic [GPIO_W-1:0] val);
		@(posedge clk);
		gpio_in <= val;
		@(negedge clk);
	endtask

	task automatic send_frame(input byte_q_t frame, input logic nak);
		int gap;
		int i;
		@(posedge clk);
		generate_nak <= nak;
		rx_in.frame_valid <= 1'b1;
		rx_in.data_valid <= 1'b1;
		rx_in.data <= frame[0];
		for (i = 1; i < frame.size(); i++) begin
			gap = int'($urandom_range(2, 0));
			repeat (gap) begin
				@(posedge clk);
				rx_in.data_valid <= 1'b0;
				rx_in.data <= 8'h00;
			end
			@(posedge clk);
			rx_in.data_valid <= 1'b1;
			rx_in.data <= frame[i];
		end
		@(posedge clk);
		rx_in.frame_valid <= 1'b0;
		rx_in.data_valid <= 1'b0;
		rx_in.data <= 8'h00;
		generate_nak <= 1'b0;
		@(posedge clk);
	endtask

	// GPIO outputs keep their old values while reply bytes are still pending
	task automatic wait_reply_drained(input string test, input logic [GPIO_W-1:0] level_before,
			input logic [GPIO_W-1:0] dir_before, input logic [GPIO_W-1:0] int_before);
		int cycles;
		cycles = 0;
		while (exp_q.size() != 0) begin
			@(negedge clk);
			cycles++;
			if (exp_q.size() != 0) begin
				compare_value(test, "gpio_level held", 32'(level_before), 32'(gpio_level));
				compare_value(test, "gpio_direction held", 32'(dir_before),
					32'(gpio_direction));
				compare_value(test, "gpio_int_enable held", 32'(int_before),
					32'(gpio_int_enable));
			end
			if (cycles > 1000) begin
				$display("Timeout in test %s: reply bytes still missing after 1000 cycles", test);
				abort_run();
			end
		end
	endtask

	// GPIO commit lands a few cycles after the reply drains
	task automatic check_settings(input string test);
		int cycles;
		cycles = 0;
		while (cycles < 50 && !settings_match()) begin
			@(negedge clk);
			cycles++;
		end
		compare_value(test, "i2c_speed", 32'(model_i2c_speed), 32'(i2c_speed));
		compare_value(test, "i2c_addr", 32'(model_i2c_addr), 32'(i2c_addr));
		compare_value(test, "gpio_level", 32'(model_gpio_level), 32'(gpio_level));
		compare_value(test, "gpio_direction", 32'(model_gpio_direction), 32'(gpio_direction));
		compare_value(test, "gpio_int_enable", 32'(model_gpio_int_enable), 32'(gpio_int_enable));
	endtask

	task automatic run_command(input string test, input byte_q_t frame, input logic nak);
		byte_q_t           reply;
		logic [GPIO_W-1:0] level_before;
		logic [GPIO_W-1:0] dir_before;
		logic [GPIO_W-1:0] int_before;
		level_before = model_gpio_level;
		dir_before = model_gpio_direction;
		int_before = model_gpio_int_enable;
		reply = expected_reply(frame, nak, gpio_in);
		cur_test = test;
		foreach (reply[k])
			exp_q.push_back({reply[k], 1'(k == reply.size() - 1)});
		send_frame(frame, nak);
		wait_reply_drained(test, level_before, dir_before, int_before);
		check_settings(test);
		repeat (3) @(negedge clk);
	endtask

	initial begin : main
		logic [7:0]  i2c_subs[2];
		logic [7:0]  gpio_subs[4];
		logic [7:0]  sub;
		logic [23:0] val;
		logic        nak;
		i2c_subs = '{SUB_I2C_SPEED, SUB_I2C_ADDR};
		gpio_subs = '{SUB_GPIO_LEVEL, SUB_GPIO_DIR, SUB_GPIO_INT, 8'h78};
		void'($urandom(66));
		rst = 1'b1;
		generate_nak = 1'b0;
		rx_in = '0;
		gpio_in = '0;
		reply_ready = 1'b1;
		ready_random = 1'b0;
		eid_next = 8'h10;
		cur_test = "reset";
		reset_model();
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);

		compare_value("reset", "reply_valid", 32'd0, 32'(reply_valid));
		check_settings("reset");
		run_command("reset", query_frame(CMD_QUERY_I2C, SUB_I2C_SPEED), 1'b0);
		run_command("reset", query_frame(CMD_QUERY_I2C, SUB_I2C_ADDR), 1'b0);

		run_command("version", version_frame(MODEL_VER_MAJOR, MODEL_VER_MINOR), 1'b0);
		run_command("version", version_frame(MODEL_VER_MAJOR, MODEL_VER_MINOR + 8'd1), 1'b0);
		run_command("version", version_frame(8'h01, MODEL_VER_MINOR), 1'b0);

		repeat (4) begin
			val = 24'($urandom);
			run_command("i2c", set_frame(CMD_SET_I2C, SUB_I2C_SPEED, val, 1), 1'b0);
			val = 24'($urandom);
			run_command("i2c", set_frame(CMD_SET_I2C, SUB_I2C_ADDR, val, 2), 1'b0);
			run_command("i2c", query_frame(CMD_QUERY_I2C, SUB_I2C_SPEED), 1'b0);
			run_command("i2c", query_frame(CMD_QUERY_I2C, SUB_I2C_ADDR), 1'b0);
		end

		for (int s = 0; s < 3; s++) begin
			val = 24'($urandom);
			run_command("gpio", set_frame(CMD_SET_GPIO, gpio_subs[s], val, 3), 1'b0);
		end
		run_command("gpio", query_frame(CMD_QUERY_GPIO, SUB_GPIO_DIR), 1'b0);
		run_command("gpio", query_frame(CMD_QUERY_GPIO, SUB_GPIO_INT), 1'b0);
		set_gpio_input(24'($urandom));
		run_command("gpio", query_frame(CMD_QUERY_GPIO, SUB_GPIO_LEVEL), 1'b0);
		run_command("gpio", query_frame(CMD_QUERY_GPIO, 8'h78), 1'b0);
		run_command("gpio", set_frame(CMD_SET_GPIO, 8'h78, 24'h123456, 3), 1'b0);

		run_command("generate_nak", query_frame(CMD_QUERY_I2C, SUB_I2C_SPEED), 1'b1);
		run_command("generate_nak", set_frame(CMD_SET_GPIO, SUB_GPIO_DIR, 24'hABCDEF, 3), 1'b1);
		run_command("generate_nak", query_frame(8'h7a, 8'h00), 1'b1);

		ready_random = 1'b1;
		repeat (40) begin
			nak = ($urandom_range(7, 0) == 0);
			val = 24'($urandom);
			set_gpio_input(24'($urandom));
			case ($urandom_range(5, 0))
				0: run_command("backpressure", version_frame(MODEL_VER_MAJOR,
					($urandom_range(1, 0) != 0) ? MODEL_VER_MINOR : 8'($urandom)), nak);
				1: begin
					sub = ($urandom_range(2, 0) == 0) ? 8'h78 : i2c_subs[$urandom_range(1, 0)];
					run_command("backpressure", query_frame(CMD_QUERY_I2C, sub), nak);
				end
				2: begin
					sub = i2c_subs[$urandom_range(1, 0)];
					run_command("backpressure", set_frame(CMD_SET_I2C, sub, val,
						(sub == SUB_I2C_SPEED) ? 1 : 2), nak);
				end
				3: run_command("backpressure",
					query_frame(CMD_QUERY_GPIO, gpio_subs[$urandom_range(3, 0)]), nak);
				4: run_command("backpressure",
					set_frame(CMD_SET_GPIO, gpio_subs[$urandom_range(3, 0)], val, 3), nak);
				default: run_command("backpressure", query_frame(8'h7a, 8'h00), nak);
			endcase
		end
		ready_random = 1'b0;
		repeat (20) @(negedge clk);

		if (exp_q.size() == 0 && !reply_valid) begin
			$display("TEST RESULT: PASS");
			$finish;
		end else begin
			$display("Reply data left unconsumed at the end of the run");
			abort_run();
		end
	end

endmodule

`default_nettype wire

// File: basics.f
+incdir+include
hdl/basics_pkg.sv
hdl/ack_generator.sv
hdl/settings_regs.sv
hdl/reply_fifo.sv
hdl/cmd_sequencer.sv
hdl/basics_top.sv
test/basics_tb.sv

// File: Makefile
SIM := obj_dir/Vbasics_tb

.PHONY: all run clean

all: run

$(SIM): basics.f hdl/*.sv test/basics_tb.sv include/basics_model.svh
	verilator --binary --timing --assert --top-module basics_tb -f basics.f -o Vbasics_tb

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir
